//--- flist.f
+incdir+include
hw/pet_pkg.sv
hw/spi1.sv
hw/spi_cmd_decoder.sv
hw/bus_master.sv
hw/main.sv
verif/tb_clk_gen.sv
verif/tb_main.sv

//--- run_sim.sh
#!/bin/sh
# Builds the SPI bridge testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_main \
    -Mdir obj_dir -o tb_main_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_main_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

//--- verif/tb_main.sv
// SPI master bit-banged at 10 clocks per SCK period; RAM model has no wait states; fixed seed
`timescale 1ns/100ps
`include "pet_params.svh"

module tb_main;
    // Ops issued over all tests, used to size the watchdog
    localparam int N_OPS   = 70;
    localparam int WDOG_NS = N_OPS * (4 * 8 * 10 + 100) * 20;
    localparam int MEM_SZ  = 1 << `PET_ADDR_W;

    logic clk;
    logic rst;
    logic spi_sck;
    logic spi_cs_n;
    logic spi_mosi;
    logic spi_miso;
    logic spi_ready;
    logic [`PET_ADDR_W-1:0] bus_addr;
    logic bus_addr_oe;
    logic [`PET_DATA_W-1:0] bus_data_in;
    logic [`PET_DATA_W-1:0] bus_data_out;
    logic bus_data_oe;
    logic bus_rw_n;
    logic bus_rw_noe;
    logic cpu_be;
    logic cpu_ready;
    logic ram_we;
    logic ram_oe;

    // RAM model and the shadow copy that the reference reads
    logic [7:0] mem [0:MEM_SZ-1];
    logic [7:0] shadow [0:MEM_SZ-1];

    // Read replies waiting for the compare process
    logic [`PET_ADDR_W-1:0] rd_addr_q[$];
    logic [7:0]             rd_data_q[$];

    int err_count = 0;
    int ctl_errs = 0;
    int cmp_count = 0;
    int strobe_cycles = 0;

    tb_clk_gen clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    main main_i (
        .clk_sys_i   (clk),
        .rst_i       (rst),
        .spi1_sck_i  (spi_sck),
        .spi1_cs_ni  (spi_cs_n),
        .spi1_rx_i   (spi_mosi),
        .spi1_tx_o   (spi_miso),
        .spi_ready_o (spi_ready),
        .bus_addr_o  (bus_addr),
        .bus_addr_oe (bus_addr_oe),
        .bus_data_i  (bus_data_in),
        .bus_data_o  (bus_data_out),
        .bus_data_oe (bus_data_oe),
        .bus_rw_no   (bus_rw_n),
        .bus_rw_noe  (bus_rw_noe),
        .cpu_be_o    (cpu_be),
        .cpu_ready_o (cpu_ready),
        .ram_we_o    (ram_we),
        .ram_oe_o    (ram_oe)
    );

    // Power-up contents built from every address bit
    function automatic logic [7:0] fill_byte(input logic [`PET_ADDR_W-1:0] a);
        return a[7:0] ^ a[15:8] ^ {a[16], 7'h35};
    endfunction

    // Expected RAM byte after all writes issued so far
    function automatic logic [7:0] ref_read(input logic [`PET_ADDR_W-1:0] a);
        return shadow[a];
    endfunction

    initial begin : fill_mem
        logic [`PET_ADDR_W-1:0] a;
        a = '0;
        repeat (MEM_SZ) begin
            mem[a]    = fill_byte(a);
            shadow[a] = fill_byte(a);
            a         = a + 1'b1;
        end
    end

    // RAM writes on the strobe, reads drive the bus only while enabled
    always @(posedge clk) begin
        if (ram_we && bus_data_oe) begin
            mem[bus_addr] <= bus_data_out;
        end
    end
    assign bus_data_in = ram_oe ? mem[bus_addr] : 8'h00;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        err_count++;
    endtask

    task automatic print_result(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", num, name, errs);
        end
    endtask

    // One SPI mode 0 byte, MSB first, MISO taken just before each rise
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        logic [7:0] shreg;
        shreg = tx;
        rx    = 8'h00;
        repeat (8) begin
            spi_mosi = shreg[7];
            repeat (5) @(negedge clk);
            rx      = {rx[6:0], spi_miso};
            spi_sck = 1'b1;
            repeat (5) @(negedge clk);
            spi_sck = 1'b0;
            shreg   = {shreg[6:0], 1'b0};
        end
    endtask

    // CS fall, then ready must have dropped
    task automatic frame_start();
        spi_cs_n = 1'b0;
        repeat (6) @(negedge clk);
        if (spi_ready !== 1'b0) begin
            report_mismatch("spi_ready_o after CS fall", 32'(spi_ready), 32'h0);
            ctl_errs++;
        end
    endtask

    task automatic frame_end();
        spi_cs_n = 1'b1;
        repeat (10) @(negedge clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!spi_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!spi_ready) begin
            $display("spi_ready_o did not rise within 200 clocks at %0t", $time);
            err_count++;
            ctl_errs++;
        end
    endtask

    task automatic spi_write(input logic [`PET_ADDR_W-1:0] addr, input logic [7:0] data);
        logic [7:0] rx;
        frame_start();
        spi_byte({2'b00, 5'd0, addr[16]}, rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        spi_byte(data, rx);
        wait_ready();
        frame_end();
        shadow[addr] = data;
    endtask

    // Reply clocked out only after ready, then queued for comparison
    task automatic spi_read(input logic [`PET_ADDR_W-1:0] addr, output logic [7:0] data);
        logic [7:0] rx;
        frame_start();
        spi_byte({2'b01, 5'd0, addr[16]}, rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        wait_ready();
        spi_byte(8'h00, data);
        frame_end();
        rd_addr_q.push_back(addr);
        rd_data_q.push_back(data);
    endtask

    // Single-byte command frame for NOP and RSVD
    task automatic spi_nop(input logic [7:0] cmd);
        logic [7:0] rx;
        frame_start();
        spi_byte(cmd, rx);
        wait_ready();
        frame_end();
    endtask

    // Compares each read reply with the reference
    initial begin : compare_replies
        logic [`PET_ADDR_W-1:0] a;
        logic [7:0]             d;
        forever begin
            @(posedge clk);
            while (rd_addr_q.size() > 0) begin
                a = rd_addr_q.pop_front();
                d = rd_data_q.pop_front();
                cmp_count++;
                if (d !== ref_read(a)) begin
                    report_mismatch($sformatf("spi1_tx_o reply for 0x%05h", a),
                                    32'(d), 32'(ref_read(a)));
                end
            end
        end
    end

    // Bus grant, ready and bus direction checked every clock
    always @(negedge clk) begin
        if (!rst) begin
            if (ram_we || ram_oe) begin
                strobe_cycles++;
            end
            if (cpu_be !== cpu_ready) begin
                report_mismatch("cpu_ready_o vs cpu_be_o", 32'(cpu_ready), 32'(cpu_be));
                ctl_errs++;
            end
            if (!cpu_be && spi_ready) begin
                report_mismatch("cpu_be_o while spi_ready_o high", 32'(cpu_be), 32'h1);
                ctl_errs++;
            end
            if ((ram_we || ram_oe || bus_addr_oe) && cpu_be) begin
                report_mismatch("cpu_be_o during bridge cycle", 32'(cpu_be), 32'h0);
                ctl_errs++;
            end
            // RW enable goes out with the address
            if (bus_rw_noe !== bus_addr_oe) begin
                report_mismatch("bus_rw_noe", 32'(bus_rw_noe), 32'(bus_addr_oe));
                ctl_errs++;
            end
            // Low RW on a write strobe, high on a read strobe and when idle
            if ((ram_we || ram_oe || !bus_addr_oe) && bus_rw_n !== !ram_we) begin
                report_mismatch("bus_rw_no", 32'(bus_rw_n), 32'(!ram_we));
                ctl_errs++;
            end
            // Data bus stays released on reads and when idle
            if ((ram_oe || !bus_addr_oe) && bus_data_oe !== 1'b0) begin
                report_mismatch("bus_data_oe", 32'(bus_data_oe), 32'h0);
                ctl_errs++;
            end
        end
    end

    initial begin : watchdog
        #(WDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : run_tests
        logic [31:0]            rnd;
        logic [`PET_ADDR_W-1:0] addr;
        logic [`PET_ADDR_W-1:0] last_wr;
        logic [7:0]             got;
        int                     errs0;
        int                     strobes0;

        spi_sck  = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        rnd      = $urandom(32'hf7c3c3c0);
        @(negedge rst);
        repeat (2) @(negedge clk);

        // Idle levels straight after reset
        errs0 = err_count;
        if (cpu_be !== 1'b1) report_mismatch("cpu_be_o", 32'(cpu_be), 32'h1);
        if (cpu_ready !== 1'b1) report_mismatch("cpu_ready_o", 32'(cpu_ready), 32'h1);
        if (bus_rw_n !== 1'b1) report_mismatch("bus_rw_no", 32'(bus_rw_n), 32'h1);
        if (bus_addr_oe !== 1'b0) report_mismatch("bus_addr_oe", 32'(bus_addr_oe), 32'h0);
        if (bus_data_oe !== 1'b0) report_mismatch("bus_data_oe", 32'(bus_data_oe), 32'h0);
        if (bus_rw_noe !== 1'b0) report_mismatch("bus_rw_noe", 32'(bus_rw_noe), 32'h0);
        if (ram_we !== 1'b0) report_mismatch("ram_we_o", 32'(ram_we), 32'h0);
        if (ram_oe !== 1'b0) report_mismatch("ram_oe_o", 32'(ram_oe), 32'h0);
        if (spi_ready !== 1'b0) report_mismatch("spi_ready_o", 32'(spi_ready), 32'h0);
        print_result(1, "reset levels", err_count - errs0);

        errs0 = err_count;
        spi_write(17'h00123, 8'h5c);
        spi_read(17'h00123, got);
        if (got !== 8'h5c) report_mismatch("spi1_tx_o reply for 0x00123", 32'(got), 32'h5c);
        last_wr = 17'h00123;
        while (rd_addr_q.size() > 0) @(negedge clk);
        print_result(2, "write then read 0x00123", err_count - errs0);

        // Random mix, A16 forced on every fourth op, reads often hit the last write
        errs0 = err_count;
        for (int i = 0; i < 64; i++) begin
            rnd  = $urandom;
            addr = rnd[16:0];
            if (i % 4 == 1) addr[16] = 1'b1;
            if (rnd[30]) begin
                spi_write(addr, rnd[24:17]);
                last_wr = addr;
            end else begin
                if (rnd[31]) addr = last_wr;
                spi_read(addr, got);
            end
        end
        while (rd_addr_q.size() > 0) @(negedge clk);
        print_result(3, "random writes and reads", err_count - errs0);

        // Write frame cut after the address bytes
        errs0    = err_count;
        strobes0 = strobe_cycles;
        addr     = 17'h1a5c3;
        frame_start();
        spi_byte(8'h01, got);
        spi_byte(addr[15:8], got);
        spi_byte(addr[7:0], got);
        frame_end();
        if (strobe_cycles != strobes0) begin
            $display("Aborted write frame still produced a RAM strobe");
            err_count++;
        end
        spi_read(addr, got);
        if (got !== ref_read(addr)) report_mismatch("spi1_tx_o after abort",
                                                    32'(got), 32'(ref_read(addr)));
        while (rd_addr_q.size() > 0) @(negedge clk);
        print_result(5, "aborted write", err_count - errs0);

        errs0    = err_count;
        strobes0 = strobe_cycles;
        spi_nop(8'h80);
        spi_nop(8'hc0);
        if (strobe_cycles != strobes0) begin
            $display("NOP or RSVD command produced %0d RAM strobe cycles",
                     strobe_cycles - strobes0);
            err_count++;
        end
        print_result(6, "nop and reserved commands", err_count - errs0);

        print_result(4, "ready and bus grant", ctl_errs);

        $display("errors: %0d, replies compared: %0d", err_count, cmp_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
// Free-running testbench clock, 20 ns by default; reset high from time zero for RST_CYCLES clocks
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int HALF_NS    = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_NS) clk_o = ~clk_o;
        end
    end

    // Released on a falling edge, away from the DUT sampling edge
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

//--- hw/main.sv
// Bridge top only; no CPU clock, reset sequencing, I/O decode, audio or video here
`timescale 1ns/100ps
`include "pet_params.svh"

module main (
    // FPGA
    input  logic                   clk_sys_i,
    input  logic                   rst_i,

    // SPI1
    input  logic                   spi1_sck_i,
    input  logic                   spi1_cs_ni,
    input  logic                   spi1_rx_i,
    output logic                   spi1_tx_o,
    output logic                   spi_ready_o,

    // System bus
    output logic [`PET_ADDR_W-1:0] bus_addr_o,
    output logic                   bus_addr_oe,
    input  logic [`PET_DATA_W-1:0] bus_data_i,
    output logic [`PET_DATA_W-1:0] bus_data_o,
    output logic                   bus_data_oe,
    output logic                   bus_rw_no,
    output logic                   bus_rw_noe,

    // CPU
    output logic                   cpu_be_o,
    output logic                   cpu_ready_o,

    // RAM
    output logic                   ram_we_o,
    output logic                   ram_oe_o
);
    logic [`PET_DATA_W-1:0] tx_byte;
    logic [`PET_DATA_W-1:0] rx_byte;
    logic                   rx_valid;
    logic                   cs_start;
    logic                   cs_end;

    pet_pkg::bus_req_t      bus_req;
    logic                   req_valid;
    logic                   bus_done;
    logic [`PET_DATA_W-1:0] bus_rdata;
    logic                   bus_own;

    spi1 spi1_i (
        .clk_i      (clk_sys_i),
        .rst_i      (rst_i),
        .spi_sck_i  (spi1_sck_i),
        .spi_cs_ni  (spi1_cs_ni),
        .spi_rx_i   (spi1_rx_i),
        .spi_tx_o   (spi1_tx_o),
        .tx_byte_i  (tx_byte),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid),
        .cs_start_o (cs_start),
        .cs_end_o   (cs_end)
    );

    spi_cmd_decoder decoder_i (
        .clk_i       (clk_sys_i),
        .rst_i       (rst_i),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .cs_start_i  (cs_start),
        .cs_end_i    (cs_end),
        .tx_byte_o   (tx_byte),
        .spi_ready_o (spi_ready_o),
        .bus_req_o   (bus_req),
        .req_valid_o (req_valid),
        .done_i      (bus_done),
        .rdata_i     (bus_rdata)
    );

    bus_master bus_master_i (
        .clk_i       (clk_sys_i),
        .rst_i       (rst_i),
        .req_i       (bus_req),
        .req_valid_i (req_valid),
        .done_o      (bus_done),
        .rdata_o     (bus_rdata),
        .own_o       (bus_own),
        .bus_addr_o  (bus_addr_o),
        .bus_data_o  (bus_data_o),
        .bus_data_oe (bus_data_oe),
        .bus_data_i  (bus_data_i),
        .bus_rw_no   (bus_rw_no),
        .ram_we_o    (ram_we_o),
        .ram_oe_o    (ram_oe_o),
        .cpu_be_o    (cpu_be_o),
        .cpu_ready_o (cpu_ready_o)
    );

    // Address and RW driven together while the bridge owns the bus
    assign bus_addr_oe = bus_own;
    assign bus_rw_noe  = bus_own;

endmodule

//--- hw/bus_master.sv
// Single RAM cycle per request with no wait states; the CPU is held off for the whole access
`timescale 1ns/100ps
`include "pet_params.svh"

module bus_master (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Request from the decoder
    input  pet_pkg::bus_req_t      req_i,
    input  logic                   req_valid_i,
    output logic                   done_o,
    output logic [`PET_DATA_W-1:0] rdata_o,

    // System bus
    output logic                   own_o,
    output logic [`PET_ADDR_W-1:0] bus_addr_o,
    output logic [`PET_DATA_W-1:0] bus_data_o,
    output logic                   bus_data_oe,
    input  logic [`PET_DATA_W-1:0] bus_data_i,
    output logic                   bus_rw_no,

    // RAM strobes and CPU grant
    output logic                   ram_we_o,
    output logic                   ram_oe_o,
    output logic                   cpu_be_o,
    output logic                   cpu_ready_o
);
    localparam int CNT_W = $clog2(`PET_STROBE_CYCLES + 1);

    pet_pkg::bus_state_e state;
    pet_pkg::bus_req_t   req_q;
    logic [CNT_W-1:0]    strobe_cnt;
    logic                strobe_last;
    logic                busy;
    logic                wr_own;

    assign strobe_last = (strobe_cnt == CNT_W'(`PET_STROBE_CYCLES - 1));

    // Phase sequence SETUP, STROBE x N, HOLD, DONE
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= pet_pkg::IDLE;
            strobe_cnt <= '0;
        end else begin
            case (state)
                pet_pkg::IDLE: begin
                    if (req_valid_i) begin
                        state <= pet_pkg::SETUP;
                    end
                end
                pet_pkg::SETUP: begin
                    strobe_cnt <= '0;
                    state      <= pet_pkg::STROBE;
                end
                pet_pkg::STROBE: begin
                    if (strobe_last) begin
                        state <= pet_pkg::HOLD;
                    end else begin
                        strobe_cnt <= strobe_cnt + 1'b1;
                    end
                end
                pet_pkg::HOLD: state <= pet_pkg::DONE;
                default:       state <= pet_pkg::IDLE;
            endcase
        end
    end

    // Request held for the whole cycle, read data taken at strobe end
    always_ff @(posedge clk_i) begin
        if (state == pet_pkg::IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (state == pet_pkg::STROBE && strobe_last && req_q.rd) begin
            rdata_o <= bus_data_i;
        end
    end

    // CPU kept off the bus until DONE is over
    assign busy   = (state != pet_pkg::IDLE);
    assign own_o  = busy && (state != pet_pkg::DONE);
    assign wr_own = own_o && !req_q.rd;

    assign cpu_be_o    = !busy;
    assign cpu_ready_o = !busy;

    assign bus_addr_o  = req_q.addr;
    assign bus_data_o  = req_q.wdata;
    assign bus_data_oe = wr_own;
    assign bus_rw_no   = !wr_own;

    assign ram_we_o = (state == pet_pkg::STROBE) && !req_q.rd;
    assign ram_oe_o = (state == pet_pkg::STROBE) && req_q.rd;
    assign done_o   = (state == pet_pkg::DONE);

    // RAM never drives and gets written at once
    a_strobe_excl : assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(ram_we_o && ram_oe_o)
    );

    // Write data settles a cycle before the strobe and stays on through it
    a_we_data : assert property (
        @(posedge clk_i) disable iff (rst_i)
        ram_we_o |-> bus_data_oe && $past(bus_data_oe)
    );

endmodule

//--- hw/spi_cmd_decoder.sv
// One bus request per CS frame at most; the SPI master must wait for spi_ready_o before the reply
`timescale 1ns/100ps
`include "pet_params.svh"

module spi_cmd_decoder (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // From spi1
    input  logic [`PET_DATA_W-1:0] rx_byte_i,
    input  logic                   rx_valid_i,
    input  logic                   cs_start_i,
    input  logic                   cs_end_i,
    output logic [`PET_DATA_W-1:0] tx_byte_o,
    output logic                   spi_ready_o,

    // To and from bus_master
    output pet_pkg::bus_req_t      bus_req_o,
    output logic                   req_valid_o,
    input  logic                   done_i,
    input  logic [`PET_DATA_W-1:0] rdata_i
);
    pet_pkg::dec_state_e state;
    pet_pkg::spi_op_e    cmd_op;

    // Opcode of the byte arriving now, meaningful in CMD only
    assign cmd_op = pet_pkg::spi_op_e'(rx_byte_i[7:6]);

    // Command FSM and ready flag
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state       <= pet_pkg::CMD;
            req_valid_o <= 1'b0;
            spi_ready_o <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;

            // Bus cycle in flight finishes whatever CS does
            if (done_i) begin
                spi_ready_o <= 1'b1;
                state       <= pet_pkg::REPLY;
            end

            if (cs_start_i) begin
                spi_ready_o <= 1'b0;
                if (state != pet_pkg::WAIT_BUS) begin
                    state <= pet_pkg::CMD;
                end
            end else if (cs_end_i) begin
                // Early CS rise drops a partial command
                if (state != pet_pkg::WAIT_BUS) begin
                    state <= pet_pkg::CMD;
                end
            end else if (rx_valid_i) begin
                case (state)
                    pet_pkg::CMD: begin
                        if (cmd_op == pet_pkg::OP_WRITE || cmd_op == pet_pkg::OP_READ) begin
                            state <= pet_pkg::ADDR_HI;
                        end else begin
                            // NOP and RSVD finish right away
                            spi_ready_o <= 1'b1;
                            state       <= pet_pkg::REPLY;
                        end
                    end
                    pet_pkg::ADDR_HI: begin
                        state <= pet_pkg::ADDR_LO;
                    end
                    pet_pkg::ADDR_LO: begin
                        if (bus_req_o.rd) begin
                            // Read goes out after the address
                            req_valid_o <= 1'b1;
                            state       <= pet_pkg::WAIT_BUS;
                        end else begin
                            state <= pet_pkg::DATA;
                        end
                    end
                    pet_pkg::DATA: begin
                        req_valid_o <= 1'b1;
                        state       <= pet_pkg::WAIT_BUS;
                    end
                    // Extra bytes in WAIT_BUS and REPLY are dropped
                    default: begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    // Request fields, filled byte by byte
    always_ff @(posedge clk_i) begin
        if (rx_valid_i) begin
            case (state)
                pet_pkg::CMD: begin
                    bus_req_o.rd                   <= (cmd_op == pet_pkg::OP_READ);
                    bus_req_o.addr[`PET_ADDR_W-1]  <= rx_byte_i[0];
                end
                pet_pkg::ADDR_HI: bus_req_o.addr[15:8] <= rx_byte_i;
                pet_pkg::ADDR_LO: bus_req_o.addr[7:0]  <= rx_byte_i;
                pet_pkg::DATA:    bus_req_o.wdata      <= rx_byte_i;
                default: begin
                    bus_req_o <= bus_req_o;
                end
            endcase
        end
    end

    // Reply byte keeps the last read value between reads
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_byte_o <= '0;
        end else if (done_i && bus_req_o.rd) begin
            tx_byte_o <= rdata_i;
        end
    end

    // No new request while one is still on the bus
    a_no_req_in_wait : assert property (
        @(posedge clk_i) disable iff (rst_i)
        req_valid_o |-> $past(state != pet_pkg::WAIT_BUS)
    );

endmodule

//--- hw/spi1.sv
// SPI mode 0 slave only; SCK period must be at least 8 clk_i cycles, CS should rise on byte bounds
`timescale 1ns/100ps
`include "pet_params.svh"

module spi1 (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // SPI pins, asynchronous to clk_i
    input  logic                   spi_sck_i,
    input  logic                   spi_cs_ni,
    input  logic                   spi_rx_i,
    output logic                   spi_tx_o,

    // Byte interface
    input  logic [`PET_DATA_W-1:0] tx_byte_i,
    output logic [`PET_DATA_W-1:0] rx_byte_o,
    output logic                   rx_valid_o,
    output logic                   cs_start_o,
    output logic                   cs_end_o
);
    localparam int BIT_W = $clog2(`PET_DATA_W);

    // Pin synchronizers, newest sample in bit 0
    logic [`PET_SPI_SYNC-1:0] sck_sync;
    logic [`PET_SPI_SYNC-1:0] cs_sync;
    logic [`PET_SPI_SYNC-1:0] rx_sync;

    logic sck_s;
    logic cs_s;
    logic rx_s;

    // Previous synchronized levels for edge detect
    logic sck_q;
    logic cs_q;

    logic sck_rise;
    logic sck_fall;

    logic [BIT_W-1:0]         bit_cnt;
    logic [`PET_DATA_W-2:0]   rx_shift;
    logic [`PET_DATA_W-1:0]   tx_shift;

    assign sck_s = sck_sync[`PET_SPI_SYNC-1];
    assign cs_s  = cs_sync[`PET_SPI_SYNC-1];
    assign rx_s  = rx_sync[`PET_SPI_SYNC-1];

    // SCK edges count only inside a frame
    assign sck_rise = sck_s & ~sck_q & ~cs_s;
    assign sck_fall = ~sck_s & sck_q & ~cs_s;

    // SCK idles low and CS idles high in mode 0
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sck_sync <= '0;
            cs_sync  <= '1;
            sck_q    <= 1'b0;
            cs_q     <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[`PET_SPI_SYNC-2:0], spi_sck_i};
            cs_sync  <= {cs_sync[`PET_SPI_SYNC-2:0], spi_cs_ni};
            sck_q    <= sck_s;
            cs_q     <= cs_s;
        end
    end

    // MOSI takes the same path as SCK so the two stay aligned
    always_ff @(posedge clk_i) begin
        rx_sync <= {rx_sync[`PET_SPI_SYNC-2:0], spi_rx_i};
    end

    // Frame start and end pulses
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cs_start_o <= 1'b0;
            cs_end_o   <= 1'b0;
        end else begin
            cs_start_o <= cs_q & ~cs_s;
            cs_end_o   <= ~cs_q & cs_s;
        end
    end

    // Bit count per byte, held at zero between frames
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (cs_s) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                // Wraps to zero after the eighth bit
                bit_cnt    <= bit_cnt + 1'b1;
                rx_valid_o <= (bit_cnt == '1);
            end
        end
    end

    // MOSI sampled MSB first on SCK rise
    always_ff @(posedge clk_i) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[`PET_DATA_W-3:0], rx_s};
            if (bit_cnt == '1) begin
                rx_byte_o <= {rx_shift, rx_s};
            end
        end
    end

    // Reply byte tracked while at a byte boundary
    // Covers both CS fall and the last fall of the previous byte
    always_ff @(posedge clk_i) begin
        if (bit_cnt == '0 && !sck_rise) begin
            tx_shift <= tx_byte_i;
        end else if (sck_fall) begin
            tx_shift <= {tx_shift[`PET_DATA_W-2:0], 1'b0};
        end
    end

    // MSB first on MISO
    assign spi_tx_o = tx_shift[`PET_DATA_W-1];

    // A byte completes only from a rise seen while CS was low
    a_rx_in_frame : assert property (
        @(posedge clk_i) disable iff (rst_i)
        rx_valid_o |-> !cs_q && $past(!cs_q)
    );

endmodule

//--- hw/pet_pkg.sv
// Types shared by the SPI bridge; struct widths follow the params header
`include "pet_params.svh"

package pet_pkg;

    // Command opcode from bits 7:6 of the first SPI byte
    typedef enum logic [1:0] {
        OP_WRITE = 2'b00,
        OP_READ  = 2'b01,
        OP_NOP   = 2'b10,
        OP_RSVD  = 2'b11
    } spi_op_e;

    // Command decoder progress through a frame
    typedef enum logic [2:0] {
        CMD      = 3'd0,
        ADDR_HI  = 3'd1,
        ADDR_LO  = 3'd2,
        DATA     = 3'd3,
        WAIT_BUS = 3'd4,
        REPLY    = 3'd5
    } dec_state_e;

    // Bus master cycle phases
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        SETUP  = 3'd1,
        STROBE = 3'd2,
        HOLD   = 3'd3,
        DONE   = 3'd4
    } bus_state_e;

    // One RAM access, read when rd is set
    typedef struct packed {
        logic                   rd;
        logic [`PET_ADDR_W-1:0] addr;
        logic [`PET_DATA_W-1:0] wdata;
    } bus_req_t;

endpackage

//--- include/pet_params.svh
// Widths are fixed by the PET bus; strobe length must be 1 or more and SPI sync depth 2 or more
`ifndef PET_PARAMS_SVH
`define PET_PARAMS_SVH

// System bus address, 128K space with A16
`define PET_ADDR_W 17

// System bus data
`define PET_DATA_W 8

// Cycles that ram_we_o or ram_oe_o stays high
`define PET_STROBE_CYCLES 2

// Flops in each SPI pin synchronizer
`define PET_SPI_SYNC 2

`endif
